// ==== verilog/legacyPassThruPkg.sv ====
//********************************************************************
// Host word addresses keep bit 0 at zero. Bit 1 picks the high half
// Register words are 32 bits and reach the host as two 16-bit halves
//********************************************************************
package legacyPassThruPkg;

    // Widths that carry a meaning
    typedef logic [11:0] hostAddr_t;
    typedef logic [15:0] hostData_t;
    typedef logic [31:0] regWord_t;
    typedef logic [17:0] sample_t;
    typedef logic [13:0] dacWord_t;
    typedef logic [3:0]  dacSel_t;
    typedef logic [31:0] clockCount_t;
    typedef logic [2:0]  resetCount_t;

    typedef enum logic [3:0] {
        modeAm         = 4'd0,
        modeFm         = 4'd1,
        mode2Fsk       = 4'd2,
        modeBpsk       = 4'd3,
        modePcmTrellis = 4'd4,
        modeSoqpsk     = 4'd5,
        modeMultih     = 4'd6
    } demodMode_t;

    //****************************************************************
    // Bundles
    //****************************************************************
    typedef struct packed {
        hostAddr_t addr;
        hostData_t wrData;
        logic      wrLow;
        logic      wrHigh;
        logic      rdStrobe;
        logic      accessStart;
    } hostReq_t;

    typedef struct packed {
        sample_t data;
        logic    sync;
    } dacTap_t;

    typedef struct packed {
        logic iBit;
        logic qBit;
        logic iSymEn;
        logic iSym2xEn;
    } legacyBits_t;

    typedef struct packed {
        logic decision;
        logic symEn;
        logic sym2xEn;
    } trellisBits_t;

    typedef struct packed {
        logic iData;
        logic qData;
        logic symEn;
        logic sym2xEn;
    } dataOut_t;

    typedef struct packed {
        dacWord_t data;
        logic     sync;
    } dacOut_t;

    //****************************************************************
    // Address map
    //****************************************************************
    // Region is address bits 11 to 4
    localparam logic [7:0] regionMisc = 8'h01;
    localparam logic [7:0] regionMode = 8'h02;

    // Register offsets are address bits 3 to 2
    localparam logic [1:0] miscResetReg   = 2'd0;
    localparam logic [1:0] miscVersionReg = 2'd1;
    localparam logic [1:0] miscClockReg   = 2'd2;

    localparam logic [1:0] modeReg    = 2'd0;
    localparam logic [1:0] dac0SelReg = 2'd1;
    localparam logic [1:0] dac1SelReg = 2'd2;
    localparam logic [1:0] dac2SelReg = 2'd3;

    localparam hostData_t versionNumber = 16'h0142;

    // DAC select codes owned by the trellis decoders
    localparam dacSel_t dacTrellisI     = 4'd12;
    localparam dacSel_t dacTrellisQ     = 4'd13;
    localparam dacSel_t dacTrellisPhErr = 4'd14;
    localparam dacSel_t dacTrellisIndex = 4'd15;

    localparam resetCount_t softResetCycles = 3'd5;

endpackage

// ==== verilog/hostBusDecode.sv ====
//********************************************************************
// Bus strobes are sampled on ck933. The host holds a write one cycle
// Read data is combinational and reads zero outside the mapped regions
//********************************************************************
`timescale 1ns/10ps

module hostBusDecode import legacyPassThruPkg::*; (
    input  logic      ck933,
    input  logic      clockCounterEn,
    input  logic      nCs,
    input  logic      nWe,
    input  logic      nRd,
    input  hostAddr_t hostAddr,
    input  hostData_t hostWrData,
    input  regWord_t  miscRdWord,
    input  regWord_t  modeRdWord,
    output hostReq_t  req,
    output logic      miscSel,
    output logic      modeSel,
    output hostData_t hostRdData
);

    logic       nCsDly;
    logic       chipWrite;
    logic [7:0] region;
    regWord_t   rdWord;

    assign chipWrite = !nCs && !nWe;
    assign region    = hostAddr[11:4];

    // Previous chip select level for the access start pulse
    always_ff @(posedge ck933 or posedge clockCounterEn) begin
        if (clockCounterEn) begin
            nCsDly <= 1'b1;
        end else begin
            nCsDly <= nCs;
        end
    end

    always_comb begin
        req.addr        = hostAddr;
        req.wrData      = hostWrData;
        req.wrLow       = chipWrite && !hostAddr[1];
        req.wrHigh      = chipWrite && hostAddr[1];
        req.rdStrobe    = !nCs && !nRd;
        req.accessStart = !nCs && nCsDly;
    end

    assign miscSel = (region == regionMisc);
    assign modeSel = (region == regionMode);

    //****************************************************************
    // Read back mux
    //****************************************************************
    always_comb begin
        if (miscSel) begin
            rdWord = miscRdWord;
        end else if (modeSel) begin
            rdWord = modeRdWord;
        end else begin
            rdWord = '0;
        end
    end

    // Half select on address bit 1
    assign hostRdData = !req.rdStrobe ? '0
                      : hostAddr[1]   ? rdWord[31:16]
                      :                 rdWord[15:0];

endmodule

// ==== verilog/miscRegs.sv ====
//********************************************************************
// Soft reset starts on a read of the reset register, not a write
// The clock hold register is undefined until the first misc access
//********************************************************************
`timescale 1ns/10ps

module miscRegs import legacyPassThruPkg::*; (
    input  logic     ck933,
    input  logic     clockCounterEn,
    input  hostReq_t req,
    input  logic     miscSel,
    output regWord_t miscRdWord,
    output logic     softReset
);

    logic [1:0]  offset;
    logic        clockWrite;
    logic        resetRead;
    clockCount_t clockCounter;
    clockCount_t clockHold;
    logic        resetFlag;
    logic        resetSync;
    resetCount_t resetCount;

    assign offset     = req.addr[3:2];
    assign clockWrite = miscSel && (req.wrLow || req.wrHigh) && (offset == miscClockReg);
    assign resetRead  = miscSel && req.rdStrobe && (offset == miscResetReg);

    always_comb begin
        case (offset)
            miscVersionReg: miscRdWord = {versionNumber, 16'h0000};
            miscClockReg:   miscRdWord = clockHold;
            default:        miscRdWord = '0;
        endcase
    end

    //****************************************************************
    // Cycle counter and capture
    //****************************************************************
    always_ff @(posedge ck933 or posedge clockCounterEn) begin
        if (clockCounterEn) begin
            clockCounter <= '0;
        end else if (clockWrite) begin
            clockCounter <= '0;
        end else begin
            clockCounter <= clockCounter + 1'b1;
        end
    end

    // Snapshot on the first cycle of any misc access
    always_ff @(posedge ck933) begin
        if (miscSel && req.accessStart) begin
            clockHold <= clockCounter;
        end
    end

    //****************************************************************
    // Soft reset request and stretch
    //****************************************************************
    always_ff @(posedge ck933 or posedge clockCounterEn) begin
        if (clockCounterEn) begin
            resetFlag  <= 1'b0;
            resetSync  <= 1'b0;
            resetCount <= '0;
        end else begin
            resetFlag <= resetRead;
            resetSync <= resetFlag;
            if (resetSync) begin
                resetCount <= softResetCycles;
            end else if (resetCount != '0) begin
                resetCount <= resetCount - 1'b1;
            end
        end
    end

    // High for the sync cycle plus the countdown
    assign softReset = resetSync || (resetCount != '0);

endmodule

// ==== verilog/modeRegs.sv ====
//********************************************************************
// Only the low lane writes these registers. The high half reads zero
//********************************************************************
`timescale 1ns/10ps

module modeRegs import legacyPassThruPkg::*; (
    input  logic       ck933,
    input  logic       clockCounterEn,
    input  logic       softReset,
    input  hostReq_t   req,
    input  logic       modeSel,
    output regWord_t   modeRdWord,
    output demodMode_t demodMode,
    output dacSel_t    dac0Sel,
    output dacSel_t    dac1Sel,
    output dacSel_t    dac2Sel
);

    logic [1:0] offset;
    logic       modeWrite;

    assign offset    = req.addr[3:2];
    assign modeWrite = modeSel && req.wrLow;

    always_ff @(posedge ck933 or posedge clockCounterEn) begin
        if (clockCounterEn) begin
            demodMode <= modeAm;
            dac0Sel   <= '0;
            dac1Sel   <= '0;
            dac2Sel   <= '0;
        end else if (softReset) begin
            demodMode <= modeAm;
            dac0Sel   <= '0;
            dac1Sel   <= '0;
            dac2Sel   <= '0;
        end else if (modeWrite) begin
            case (offset)
                modeReg:    demodMode <= demodMode_t'(req.wrData[3:0]);
                dac0SelReg: dac0Sel   <= req.wrData[3:0];
                dac1SelReg: dac1Sel   <= req.wrData[3:0];
                default:    dac2Sel   <= req.wrData[3:0];
            endcase
        end
    end

    always_comb begin
        case (offset)
            modeReg:    modeRdWord = {28'd0, demodMode};
            dac0SelReg: modeRdWord = {28'd0, dac0Sel};
            dac1SelReg: modeRdWord = {28'd0, dac1Sel};
            default:    modeRdWord = {28'd0, dac2Sel};
        endcase
    end

endmodule

// ==== verilog/demodOutputSelect.sv ====
//********************************************************************
// Trellis bits take two cycles to dataOut, legacy bits take one
// Lock outputs are combinational and active low
//********************************************************************
`timescale 1ns/10ps

module demodOutputSelect import legacyPassThruPkg::*; (
    input  logic         ck933,
    input  logic         clockCounterEn,
    input  logic         softReset,
    input  demodMode_t   demodMode,
    input  legacyBits_t  legacyIn,
    input  trellisBits_t pcmIn,
    input  trellisBits_t soqpskIn,
    input  logic         bitsyncLock,
    input  logic         carrierLock,
    input  logic         multihLock,
    output dataOut_t     dataOut,
    output logic         bsyncNLock,
    output logic         demodNLock
);

    logic         pcmMode;
    logic         trellisEn;
    logic         fmMode;
    trellisBits_t trellisReg;

    assign pcmMode   = (demodMode == modePcmTrellis);
    assign trellisEn = pcmMode || (demodMode == modeSoqpsk);
    assign fmMode    = (demodMode == modeFm) || (demodMode == mode2Fsk);

    always_ff @(posedge ck933 or posedge clockCounterEn) begin
        if (clockCounterEn) begin
            trellisReg <= '0;
            dataOut    <= '0;
        end else if (softReset) begin
            trellisReg <= '0;
            dataOut    <= '0;
        end else begin
            // PCM decision polarity is flipped here
            trellisReg <= pcmMode ? trellisBits_t'{!pcmIn.decision, pcmIn.symEn, pcmIn.sym2xEn}
                                  : soqpskIn;
            if (trellisEn) begin
                dataOut <= '{trellisReg.decision, trellisReg.decision,
                             trellisReg.symEn, trellisReg.sym2xEn};
            end else begin
                dataOut <= '{legacyIn.iBit ^ fmMode, legacyIn.qBit,
                             legacyIn.iSymEn, legacyIn.iSym2xEn};
            end
        end
    end

    assign bsyncNLock = !bitsyncLock;
    assign demodNLock = (demodMode == modeMultih) ? !multihLock : !carrierLock;

endmodule

// ==== verilog/dacSourceMux.sv ====
//********************************************************************
// One DAC channel. Only sample bits 17 to 4 reach the pins
//********************************************************************
`timescale 1ns/10ps

module dacSourceMux import legacyPassThruPkg::*; (
    input  logic       ck933,
    input  logic       clockCounterEn,
    input  logic       softReset,
    input  demodMode_t demodMode,
    input  dacSel_t    dacSel,
    input  dacTap_t    demodTap,
    input  dacTap_t    pcmTap,
    input  dacTap_t    soqpskTap,
    input  dacTap_t    multihTap,
    input  logic       multihTapEn,
    output dacOut_t    dacOut
);

    dacTap_t chosen;

    always_comb begin
        case (dacSel)
            dacTrellisI, dacTrellisQ, dacTrellisPhErr, dacTrellisIndex: begin
                chosen = (demodMode == modePcmTrellis) ? pcmTap : soqpskTap;
            end
            default: begin
                // Multi-h taps only when the loop claims this channel
                chosen = ((demodMode == modeMultih) && multihTapEn) ? multihTap : demodTap;
            end
        endcase
    end

    always_ff @(posedge ck933 or posedge clockCounterEn) begin
        if (clockCounterEn) begin
            dacOut <= '0;
        end else if (softReset) begin
            dacOut <= '0;
        end else begin
            dacOut.data <= chosen.data[17:4];
            dacOut.sync <= chosen.sync;
        end
    end

endmodule

// ==== verilog/legacyPassThru.sv ====
//********************************************************************
// Demod, trellis and multi-h taps arrive as inputs on ck933
// clockCounterEn is the asynchronous active-high reset
//********************************************************************
`timescale 1ns/10ps

module legacyPassThru import legacyPassThruPkg::*; (
    input  logic         ck933,
    input  logic         clockCounterEn,
    input  logic         nCs,
    input  logic         nWe,
    input  logic         nRd,
    input  hostAddr_t    hostAddr,
    input  hostData_t    hostWrData,
    input  legacyBits_t  legacyIn,
    input  trellisBits_t pcmIn,
    input  trellisBits_t soqpskIn,
    input  logic         bitsyncLock,
    input  logic         carrierLock,
    input  logic         multihLock,
    input  dacTap_t      demodTap0,
    input  dacTap_t      demodTap1,
    input  dacTap_t      demodTap2,
    input  dacTap_t      trellisTap0,
    input  dacTap_t      trellisTap1,
    input  dacTap_t      trellisTap2,
    input  dacTap_t      soqpskTap0,
    input  dacTap_t      soqpskTap1,
    input  dacTap_t      soqpskTap2,
    input  dacTap_t      multihTap0,
    input  dacTap_t      multihTap1,
    input  dacTap_t      multihTap2,
    input  logic [2:0]   multihTapEn,
    output hostData_t    hostRdData,
    output demodMode_t   demodMode,
    output dataOut_t     dataOut,
    output logic         bsyncNLock,
    output logic         demodNLock,
    output dacOut_t      dac0Out,
    output dacOut_t      dac1Out,
    output dacOut_t      dac2Out
);

    hostReq_t req;
    logic     miscSel;
    logic     modeSel;
    regWord_t miscRdWord;
    regWord_t modeRdWord;
    logic     softReset;
    dacSel_t  dac0Sel;
    dacSel_t  dac1Sel;
    dacSel_t  dac2Sel;

    //****************************************************************
    // Host side
    //****************************************************************
    hostBusDecode busDecode (
        .ck933(ck933), .clockCounterEn(clockCounterEn),
        .nCs(nCs), .nWe(nWe), .nRd(nRd),
        .hostAddr(hostAddr), .hostWrData(hostWrData),
        .miscRdWord(miscRdWord), .modeRdWord(modeRdWord),
        .req(req), .miscSel(miscSel), .modeSel(modeSel),
        .hostRdData(hostRdData)
    );

    miscRegs misc (
        .ck933(ck933), .clockCounterEn(clockCounterEn),
        .req(req), .miscSel(miscSel),
        .miscRdWord(miscRdWord), .softReset(softReset)
    );

    modeRegs mode (
        .ck933(ck933), .clockCounterEn(clockCounterEn), .softReset(softReset),
        .req(req), .modeSel(modeSel), .modeRdWord(modeRdWord),
        .demodMode(demodMode),
        .dac0Sel(dac0Sel), .dac1Sel(dac1Sel), .dac2Sel(dac2Sel)
    );

    //****************************************************************
    // Data bits and DAC channels
    //****************************************************************
    demodOutputSelect outSelect (
        .ck933(ck933), .clockCounterEn(clockCounterEn), .softReset(softReset),
        .demodMode(demodMode), .legacyIn(legacyIn),
        .pcmIn(pcmIn), .soqpskIn(soqpskIn),
        .bitsyncLock(bitsyncLock), .carrierLock(carrierLock), .multihLock(multihLock),
        .dataOut(dataOut), .bsyncNLock(bsyncNLock), .demodNLock(demodNLock)
    );

    dacSourceMux dacMux0 (
        .ck933(ck933), .clockCounterEn(clockCounterEn), .softReset(softReset),
        .demodMode(demodMode), .dacSel(dac0Sel),
        .demodTap(demodTap0), .pcmTap(trellisTap0), .soqpskTap(soqpskTap0),
        .multihTap(multihTap0), .multihTapEn(multihTapEn[0]), .dacOut(dac0Out)
    );

    dacSourceMux dacMux1 (
        .ck933(ck933), .clockCounterEn(clockCounterEn), .softReset(softReset),
        .demodMode(demodMode), .dacSel(dac1Sel),
        .demodTap(demodTap1), .pcmTap(trellisTap1), .soqpskTap(soqpskTap1),
        .multihTap(multihTap1), .multihTapEn(multihTapEn[1]), .dacOut(dac1Out)
    );

    dacSourceMux dacMux2 (
        .ck933(ck933), .clockCounterEn(clockCounterEn), .softReset(softReset),
        .demodMode(demodMode), .dacSel(dac2Sel),
        .demodTap(demodTap2), .pcmTap(trellisTap2), .soqpskTap(soqpskTap2),
        .multihTap(multihTap2), .multihTapEn(multihTapEn[2]), .dacOut(dac2Out)
    );

endmodule

// ==== verification/legacyPassThruTb.sv ====
//**********************************************************************
// Host accesses start 1 ns after the rising edge. Reads hold nCs low two
// cycles so the clock hold register is captured before it is sampled
//**********************************************************************
`timescale 1ns/10ps

module legacyPassThruTb import legacyPassThruPkg::*; ();

    // One table row. Source codes are 0 demod, 1 pcm, 2 soqpsk, 3 multi-h
    typedef struct packed {
        demodMode_t   mode;
        dacSel_t      sel0;
        dacSel_t      sel1;
        dacSel_t      sel2;
        legacyBits_t  legacy;
        trellisBits_t pcm;
        trellisBits_t soqpsk;
        logic [2:0]   locks;
        logic [2:0]   tapEn;
        logic [4:0]   gap;
        dataOut_t     expData;
        logic         expBsyncN;
        logic         expDemodN;
        logic [1:0]   src0;
        logic [1:0]   src1;
        logic [1:0]   src2;
    } stimRow_t;

    localparam int numRows    = 9;
    localparam int cycleLimit = 40 * numRows + 200;

    localparam hostAddr_t versionHighAddr = {regionMisc, miscVersionReg, 2'b10};
    localparam hostAddr_t versionLowAddr  = {regionMisc, miscVersionReg, 2'b00};
    localparam hostAddr_t resetAddr       = {regionMisc, miscResetReg, 2'b00};
    localparam hostAddr_t clockAddr       = {regionMisc, miscClockReg, 2'b00};
    localparam hostAddr_t modeAddr        = {regionMode, modeReg, 2'b00};
    localparam hostAddr_t dac0Addr        = {regionMode, dac0SelReg, 2'b00};
    localparam hostAddr_t dac1Addr        = {regionMode, dac1SelReg, 2'b00};
    localparam hostAddr_t dac2Addr        = {regionMode, dac2SelReg, 2'b00};
    localparam hostAddr_t unmappedAddr    = 12'h3F4;

    logic         ck933 = 1'b0;
    logic         clockCounterEn;
    logic         nCs;
    logic         nWe;
    logic         nRd;
    hostAddr_t    hostAddr;
    hostData_t    hostWrData;
    legacyBits_t  legacyIn;
    trellisBits_t pcmIn;
    trellisBits_t soqpskIn;
    logic         bitsyncLock;
    logic         carrierLock;
    logic         multihLock;
    dacTap_t      demodTaps [3];
    dacTap_t      pcmTaps [3];
    dacTap_t      soqpskTaps [3];
    dacTap_t      multihTaps [3];
    logic [2:0]   multihTapEn;
    hostData_t    hostRdData;
    demodMode_t   demodMode;
    dataOut_t     dataOut;
    logic         bsyncNLock;
    logic         demodNLock;
    dacOut_t      dacOuts [3];
    stimRow_t     stimTable [numRows];
    int           cycleCount = 0;

    legacyPassThru dut0 (
        .ck933(ck933), .clockCounterEn(clockCounterEn),
        .nCs(nCs), .nWe(nWe), .nRd(nRd),
        .hostAddr(hostAddr), .hostWrData(hostWrData),
        .legacyIn(legacyIn), .pcmIn(pcmIn), .soqpskIn(soqpskIn),
        .bitsyncLock(bitsyncLock), .carrierLock(carrierLock), .multihLock(multihLock),
        .demodTap0(demodTaps[0]), .demodTap1(demodTaps[1]), .demodTap2(demodTaps[2]),
        .trellisTap0(pcmTaps[0]), .trellisTap1(pcmTaps[1]), .trellisTap2(pcmTaps[2]),
        .soqpskTap0(soqpskTaps[0]), .soqpskTap1(soqpskTaps[1]), .soqpskTap2(soqpskTaps[2]),
        .multihTap0(multihTaps[0]), .multihTap1(multihTaps[1]), .multihTap2(multihTaps[2]),
        .multihTapEn(multihTapEn),
        .hostRdData(hostRdData), .demodMode(demodMode), .dataOut(dataOut),
        .bsyncNLock(bsyncNLock), .demodNLock(demodNLock),
        .dac0Out(dacOuts[0]), .dac1Out(dacOuts[1]), .dac2Out(dacOuts[2])
    );

    always #4 ck933 = ~ck933;

    always @(posedge ck933) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= cycleLimit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycleLimit);
            $display("TB FAILED");
            $fatal(1, "Run stopped at the cycle limit");
        end
    end

    //******************************************************************
    // Helpers
    //******************************************************************
    task automatic checkValue(input string testName, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (expected !== actual) begin
            $display("Fail %s expected %0h actual %0h", testName, expected, actual);
            $display("TB FAILED");
            $fatal(1, "Mismatch in %s", testName);
        end
    endtask

    task automatic idleCycles(input int n);
        repeat (n) begin
            @(posedge ck933);
            #1;
        end
    endtask

    // Write strobe is active for exactly one cycle
    task automatic hostWrite(input hostAddr_t addr, input hostData_t data);
        nCs = 1'b0;
        nWe = 1'b0;
        hostAddr = addr;
        hostWrData = data;
        @(posedge ck933);
        #1;
        nCs = 1'b1;
        nWe = 1'b1;
    endtask

    task automatic hostRead(input hostAddr_t addr, output hostData_t data);
        nCs = 1'b0;
        nRd = 1'b0;
        hostAddr = addr;
        idleCycles(1);
        @(negedge ck933);
        data = hostRdData;
        @(posedge ck933);
        #1;
        nCs = 1'b1;
        nRd = 1'b1;
    endtask

    task automatic randomizeTaps();
        logic [31:0] r;
        for (int c = 0; c < 3; c++) begin
            r = $urandom;
            demodTaps[c] = r[18:0];
            r = $urandom;
            pcmTaps[c] = r[18:0];
            r = $urandom;
            soqpskTaps[c] = r[18:0];
            r = $urandom;
            multihTaps[c] = r[18:0];
        end
    endtask

    function automatic dacOut_t expectedDac(input logic [1:0] src, input int ch);
        dacTap_t tap;
        dacOut_t result;
        case (src)
            2'd0:    tap = demodTaps[ch];
            2'd1:    tap = pcmTaps[ch];
            2'd2:    tap = soqpskTaps[ch];
            default: tap = multihTaps[ch];
        endcase
        result.data = tap.data[17:4];
        result.sync = tap.sync;
        return result;
    endfunction

    // Captures that start gap cycles apart must differ by gap
    task automatic clockGapTest(input string testName, input int gap);
        hostData_t firstHold;
        hostData_t secondHold;
        hostWrite(clockAddr, 16'h0000);
        idleCycles(1);
        hostRead(clockAddr, firstHold);
        idleCycles(gap - 2);
        hostRead(clockAddr, secondHold);
        checkValue(testName, 32'(gap), 32'(hostData_t'(secondHold - firstHold)));
    endtask

    // mode, sel0..2, legacy, pcm, soqpsk, locks {bsync,carrier,multih}, tapEn, gap,
    // expected dataOut, bsyncN, demodN, dac sources 0..2
    task automatic loadTable();
        stimTable[0] = '{modeAm, 4'd0, 4'd3, 4'd12, 4'b1011, 3'b101, 3'b010, 3'b101,
                         3'b111, 5'd5, 4'b1011, 1'b0, 1'b1, 2'd0, 2'd0, 2'd2};
        stimTable[1] = '{modeFm, 4'd13, 4'd1, 4'd7, 4'b1100, 3'b011, 3'b110, 3'b010,
                         3'b000, 5'd7, 4'b0100, 1'b1, 1'b0, 2'd2, 2'd0, 2'd0};
        stimTable[2] = '{mode2Fsk, 4'd2, 4'd14, 4'd15, 4'b0011, 3'b000, 3'b111, 3'b111,
                         3'b010, 5'd4, 4'b1011, 1'b0, 1'b0, 2'd0, 2'd2, 2'd2};
        stimTable[3] = '{modeBpsk, 4'd5, 4'd12, 4'd0, 4'b0110, 3'b111, 3'b001, 3'b000,
                         3'b101, 5'd9, 4'b0110, 1'b1, 1'b1, 2'd0, 2'd2, 2'd0};
        stimTable[4] = '{modePcmTrellis, 4'd12, 4'd15, 4'd9, 4'b1111, 3'b011, 3'b100,
                         3'b110, 3'b111, 5'd6, 4'b1111, 1'b0, 1'b0, 2'd1, 2'd1, 2'd0};
        stimTable[5] = '{modeSoqpsk, 4'd14, 4'd4, 4'd13, 4'b0000, 3'b110, 3'b101, 3'b001,
                         3'b111, 5'd11, 4'b1101, 1'b1, 1'b1, 2'd2, 2'd0, 2'd2};
        stimTable[6] = '{modeMultih, 4'd1, 4'd2, 4'd3, 4'b1001, 3'b101, 3'b011, 3'b011,
                         3'b101, 5'd3, 4'b1001, 1'b1, 1'b0, 2'd3, 2'd0, 2'd3};
        stimTable[7] = '{modeMultih, 4'd12, 4'd8, 4'd0, 4'b0101, 3'b100, 3'b110, 3'b110,
                         3'b110, 5'd12, 4'b0101, 1'b0, 1'b1, 2'd2, 2'd3, 2'd3};
        stimTable[8] = '{modePcmTrellis, 4'd0, 4'd13, 4'd14, 4'b1010, 3'b110, 3'b001,
                         3'b100, 3'b000, 5'd8, 4'b0010, 1'b0, 1'b1, 2'd0, 2'd1, 2'd1};
    endtask

    //******************************************************************
    // Main sequence
    //******************************************************************
    initial begin
        stimRow_t  row;
        hostData_t rdData;
        string     tag;
        void'($urandom(31205));
        loadTable();
        clockCounterEn = 1'b1;
        nCs = 1'b1;
        nWe = 1'b1;
        nRd = 1'b1;
        hostAddr = '0;
        hostWrData = '0;
        legacyIn = '0;
        pcmIn = '0;
        soqpskIn = '0;
        bitsyncLock = 1'b0;
        carrierLock = 1'b0;
        multihLock = 1'b0;
        multihTapEn = '0;
        for (int c = 0; c < 3; c++) begin
            demodTaps[c] = '0;
            pcmTaps[c] = '0;
            soqpskTaps[c] = '0;
            multihTaps[c] = '0;
        end
        repeat (3) @(posedge ck933);
        #1;
        clockCounterEn = 1'b0;

        checkValue("reset dataOut", 32'h0, 32'(dataOut));
        checkValue("reset demodMode", 32'(modeAm), 32'(demodMode));
        checkValue("reset dac0", 32'h0, 32'(dacOuts[0]));

        hostRead(versionHighAddr, rdData);
        checkValue("version high", 32'(versionNumber), 32'(rdData));
        hostRead(versionLowAddr, rdData);
        checkValue("version low", 32'h0, 32'(rdData));
        hostRead(unmappedAddr, rdData);
        checkValue("unmapped read", 32'h0, 32'(rdData));

        for (int i = 0; i < numRows; i++) begin
            row = stimTable[i];
            tag = $sformatf("row%0d", i);
            hostWrite(modeAddr, {12'd0, row.mode});
            hostWrite(dac0Addr, {12'd0, row.sel0});
            hostWrite(dac1Addr, {12'd0, row.sel1});
            hostWrite(dac2Addr, {12'd0, row.sel2});
            hostRead(modeAddr, rdData);
            checkValue({tag, " mode read"}, 32'(row.mode), 32'(rdData));
            checkValue({tag, " demodMode port"}, 32'(row.mode), 32'(demodMode));
            hostRead(dac0Addr, rdData);
            checkValue({tag, " dac0Sel read"}, 32'(row.sel0), 32'(rdData));
            hostRead(dac1Addr, rdData);
            checkValue({tag, " dac1Sel read"}, 32'(row.sel1), 32'(rdData));
            hostRead(dac2Addr, rdData);
            checkValue({tag, " dac2Sel read"}, 32'(row.sel2), 32'(rdData));

            // Hold the row long enough for the two-stage trellis path
            legacyIn = row.legacy;
            pcmIn = row.pcm;
            soqpskIn = row.soqpsk;
            bitsyncLock = row.locks[2];
            carrierLock = row.locks[1];
            multihLock = row.locks[0];
            multihTapEn = row.tapEn;
            randomizeTaps();
            idleCycles(4);

            checkValue({tag, " dataOut"}, 32'(row.expData), 32'(dataOut));
            checkValue({tag, " bsyncNLock"}, 32'(row.expBsyncN), 32'(bsyncNLock));
            checkValue({tag, " demodNLock"}, 32'(row.expDemodN), 32'(demodNLock));
            checkValue({tag, " dac0Out"}, 32'(expectedDac(row.src0, 0)), 32'(dacOuts[0]));
            checkValue({tag, " dac1Out"}, 32'(expectedDac(row.src1, 1)), 32'(dacOuts[1]));
            checkValue({tag, " dac2Out"}, 32'(expectedDac(row.src2, 2)), 32'(dacOuts[2]));
            clockGapTest({tag, " clock gap"}, int'(row.gap));
        end

        // Every select off its default before the soft reset
        hostWrite(dac0Addr, 16'h0009);
        hostRead(dac0Addr, rdData);
        checkValue("pre reset dac0Sel", 32'h9, 32'(rdData));

        // Soft reset starts on a read of the reset register
        hostRead(resetAddr, rdData);
        idleCycles(12);
        hostRead(modeAddr, rdData);
        checkValue("soft reset mode", 32'(modeAm), 32'(rdData));
        checkValue("soft reset demodMode", 32'(modeAm), 32'(demodMode));
        hostRead(dac0Addr, rdData);
        checkValue("soft reset dac0Sel", 32'h0, 32'(rdData));
        hostRead(dac1Addr, rdData);
        checkValue("soft reset dac1Sel", 32'h0, 32'(rdData));
        hostRead(dac2Addr, rdData);
        checkValue("soft reset dac2Sel", 32'h0, 32'(rdData));
        hostRead(versionHighAddr, rdData);
        checkValue("soft reset version", 32'(versionNumber), 32'(rdData));

        $display("TB PASSED");
        $finish;
    end

endmodule

// ==== legacyPassThru.f ====
verilog/legacyPassThruPkg.sv
verilog/hostBusDecode.sv
verilog/miscRegs.sv
verilog/modeRegs.sv
verilog/demodOutputSelect.sv
verilog/dacSourceMux.sv
verilog/legacyPassThru.sv
verification/legacyPassThruTb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --timing
TOP       = legacyPassThruTb
FILELIST  = legacyPassThru.f
OBJDIR    = obj_dir
PASSTEXT  = TB PASSED

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJDIR)
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASSTEXT)"

clean:
	rm -rf $(OBJDIR)
